// ==== hw/axil_sr_cfg.svh ====
`ifndef AXIL_SR_CFG_SVH
`define AXIL_SR_CFG_SVH

// bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define SR_DATA_W   64

// log2 queue depths
`define WR_Q_LOG_DEPTH   3
`define RD_Q_LOG_DEPTH   3
`define BUF_Q_LOG_DEPTH  1
`define RESP_Q_LOG_DEPTH 3

// B response and R credit counters
`define RESP_CNT_W 8

`endif

// ==== hw/axil_sr_pkg.sv ====
package axil_sr_pkg;

    //////////////////////////////////////////////////
    // softreg side
    //////////////////////////////////////////////////

    typedef enum logic {
        SR_READ  = 1'b0,
        SR_WRITE = 1'b1
    } sr_op_t;

    // which 32-bit half of a 64-bit word comes next
    typedef enum logic {
        HALF_LO = 1'b0,
        HALF_HI = 1'b1
    } half_sel_t;

    //////////////////////////////////////////////////
    // axi side
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_t;

endpackage

// ==== hw/sr_req_if.sv ====
`include "axil_sr_cfg.svh"

interface sr_req_if import axil_sr_pkg::*; ();

    logic                    valid;
    logic                    ready;
    sr_op_t                  op;
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [`SR_DATA_W-1:0]   data;

    // source holds op, addr and data steady while valid waits for ready
    modport source (
        output valid, op, addr, data,
        input  ready
    );

    modport sink (
        input  valid, op, addr, data,
        output ready
    );

endinterface

// ==== hw/sr_fifo.sv ====
module sr_fifo #(
    parameter int WIDTH     = 32,
    parameter int LOG_DEPTH = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    output logic             full,
    input  logic             pop,
    output logic [WIDTH-1:0] head,
    output logic             empty
);

    localparam int DEPTH = 2 ** LOG_DEPTH;
    localparam logic [LOG_DEPTH:0] FULL_CNT = DEPTH[LOG_DEPTH:0];

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [LOG_DEPTH-1:0] wr_ptr;
    logic [LOG_DEPTH-1:0] rd_ptr;
    logic [LOG_DEPTH:0]   count;
    logic                 do_push;
    logic                 do_pop;

    assign full    = (count == FULL_CNT);
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // oldest entry shows with no read latency
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{LOG_DEPTH{1'b0}}, do_push} - {{LOG_DEPTH{1'b0}}, do_pop};
        end
    end

endmodule

// ==== hw/axil_write_pairer.sv ====
`include "axil_sr_cfg.svh"

module axil_write_pairer import axil_sr_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    awvalid,
    input  logic [`AXIL_ADDR_W-1:0] awaddr,
    output logic                    awready,
    input  logic                    wvalid,
    input  logic [`AXIL_DATA_W-1:0] wdata,
    output logic                    wready,
    output logic                    bvalid,
    output axi_resp_t               bresp,
    input  logic                    bready,
    sr_req_if.source                wr_req
);

    logic                    aw_hs, w_hs, b_hs, wr_xfer;
    half_sel_t               aw_half, w_half;
    logic                    addr_push, addr_full, addr_empty;
    logic [`AXIL_ADDR_W-1:0] addr_head;
    logic                    lo_push, lo_full, lo_empty;
    logic                    hi_push, hi_full, hi_empty;
    logic [`AXIL_DATA_W-1:0] lo_head, hi_head;
    logic [`RESP_CNT_W-1:0]  b_cnt;

    //////////////////////////////////////////////////
    // address channel, keep the first of each pair
    //////////////////////////////////////////////////

    assign awready   = !addr_full;
    assign aw_hs     = awvalid && awready;
    assign addr_push = aw_hs && (aw_half == HALF_LO);

    sr_fifo #(.WIDTH(`AXIL_ADDR_W), .LOG_DEPTH(`WR_Q_LOG_DEPTH)) u_addr_q (
        .clk(clk), .rst(rst),
        .push(addr_push), .push_data(awaddr), .full(addr_full),
        .pop(wr_xfer), .head(addr_head), .empty(addr_empty)
    );

    //////////////////////////////////////////////////
    // data channel, alternate low and high queues
    //////////////////////////////////////////////////

    // room in both so the beat lands regardless of which half is next
    assign wready  = !lo_full && !hi_full;
    assign w_hs    = wvalid && wready;
    assign lo_push = w_hs && (w_half == HALF_LO);
    assign hi_push = w_hs && (w_half == HALF_HI);

    sr_fifo #(.WIDTH(`AXIL_DATA_W), .LOG_DEPTH(`WR_Q_LOG_DEPTH)) u_lo_q (
        .clk(clk), .rst(rst),
        .push(lo_push), .push_data(wdata), .full(lo_full),
        .pop(wr_xfer), .head(lo_head), .empty(lo_empty)
    );

    sr_fifo #(.WIDTH(`AXIL_DATA_W), .LOG_DEPTH(`WR_Q_LOG_DEPTH)) u_hi_q (
        .clk(clk), .rst(rst),
        .push(hi_push), .push_data(wdata), .full(hi_full),
        .pop(wr_xfer), .head(hi_head), .empty(hi_empty)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_half <= HALF_LO;
            w_half  <= HALF_LO;
            b_cnt   <= '0;
        end else begin
            if (aw_hs) begin
                aw_half <= (aw_half == HALF_LO) ? HALF_HI : HALF_LO;
            end
            if (w_hs) begin
                w_half <= (w_half == HALF_LO) ? HALF_HI : HALF_LO;
            end
            // one B response owed per accepted W beat
            case ({w_hs, b_hs})
                2'b10:   b_cnt <= b_cnt + 1'b1;
                2'b01:   b_cnt <= b_cnt - 1'b1;
                default: b_cnt <= b_cnt;
            endcase
        end
    end

    assign bvalid = (b_cnt != '0);
    assign bresp  = RESP_OKAY;
    assign b_hs   = bvalid && bready;

    // paired request once address and both halves are present
    assign wr_req.valid = !addr_empty && !lo_empty && !hi_empty;
    assign wr_req.op    = SR_WRITE;
    assign wr_req.addr  = addr_head;
    assign wr_req.data  = {hi_head, lo_head};
    assign wr_xfer      = wr_req.valid && wr_req.ready;

endmodule

// ==== hw/axil_read_pairer.sv ====
`include "axil_sr_cfg.svh"

module axil_read_pairer import axil_sr_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    arvalid,
    input  logic [`AXIL_ADDR_W-1:0] araddr,
    output logic                    arready,
    sr_req_if.source                rd_req,
    output logic                    ar_accept
);

    logic                    ar_hs;
    half_sel_t               ar_half;
    logic                    q_push, q_pop, q_full, q_empty;
    logic [`AXIL_ADDR_W-1:0] q_head;

    assign arready = !q_full;
    assign ar_hs   = arvalid && arready;

    // only the first beat of a pair becomes a softreg read
    assign q_push = ar_hs && (ar_half == HALF_LO);

    // every beat earns one R credit downstream
    assign ar_accept = ar_hs;

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_half <= HALF_LO;
        end else if (ar_hs) begin
            ar_half <= (ar_half == HALF_LO) ? HALF_HI : HALF_LO;
        end
    end

    sr_fifo #(.WIDTH(`AXIL_ADDR_W), .LOG_DEPTH(`RD_Q_LOG_DEPTH)) u_ar_q (
        .clk      (clk),
        .rst      (rst),
        .push     (q_push),
        .push_data(araddr),
        .full     (q_full),
        .pop      (q_pop),
        .head     (q_head),
        .empty    (q_empty)
    );

    //////////////////////////////////////////////////
    // read request out
    //////////////////////////////////////////////////

    assign rd_req.valid = !q_empty;
    assign rd_req.op    = SR_READ;
    assign rd_req.addr  = q_head;
    assign rd_req.data  = '0;
    assign q_pop        = rd_req.valid && rd_req.ready;

endmodule

// ==== hw/sr_req_arbiter.sv ====
`include "axil_sr_cfg.svh"

module sr_req_arbiter import axil_sr_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    sr_req_if.sink wr_req,
    sr_req_if.sink rd_req,
    sr_req_if.source sr_out
);

    localparam int REQ_W  = 1 + `AXIL_ADDR_W + `SR_DATA_W;
    localparam int ADDR_HI = REQ_W - 2;

    logic             take_wr;
    logic             take_rd;
    logic             buf_push;
    logic             buf_pop;
    logic             buf_full;
    logic             buf_empty;
    logic [REQ_W-1:0] buf_in;
    logic [REQ_W-1:0] buf_head;

    //////////////////////////////////////////////////
    // write over read
    //////////////////////////////////////////////////

    assign wr_req.ready = !buf_full;
    assign rd_req.ready = !buf_full && !wr_req.valid;

    assign take_wr  = wr_req.valid && wr_req.ready;
    assign take_rd  = rd_req.valid && rd_req.ready;
    assign buf_push = take_wr || take_rd;

    assign buf_in = take_wr ? {wr_req.op, wr_req.addr, wr_req.data}
                            : {rd_req.op, rd_req.addr, rd_req.data};

    // timing buffer in front of the softreg port
    sr_fifo #(.WIDTH(REQ_W), .LOG_DEPTH(`BUF_Q_LOG_DEPTH)) u_buf_q (
        .clk      (clk),
        .rst      (rst),
        .push     (buf_push),
        .push_data(buf_in),
        .full     (buf_full),
        .pop      (buf_pop),
        .head     (buf_head),
        .empty    (buf_empty)
    );

    assign sr_out.valid = !buf_empty;
    assign sr_out.op    = sr_op_t'(buf_head[REQ_W-1]);
    assign sr_out.addr  = buf_head[ADDR_HI -: `AXIL_ADDR_W];
    assign sr_out.data  = buf_head[`SR_DATA_W-1:0];

    // head stays put until the softreg side grants it
    assign buf_pop = sr_out.valid && sr_out.ready;

endmodule

// ==== hw/sr_read_responder.sv ====
`include "axil_sr_cfg.svh"

module sr_read_responder import axil_sr_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    resp_valid,
    input  logic [`SR_DATA_W-1:0]   resp_data,
    output logic                    resp_grant,
    input  logic                    ar_accept,
    output logic                    rvalid,
    output logic [`AXIL_DATA_W-1:0] rdata,
    output axi_resp_t               rresp,
    input  logic                    rready
);

    logic                   q_push;
    logic                   q_pop;
    logic                   q_full;
    logic                   q_empty;
    logic [`SR_DATA_W-1:0]  q_head;
    logic                   r_hs;
    half_sel_t              r_half;
    logic [`RESP_CNT_W-1:0] credit;

    //////////////////////////////////////////////////
    // softreg response capture
    //////////////////////////////////////////////////

    assign q_push     = resp_valid && !q_full;
    assign resp_grant = q_push;

    sr_fifo #(.WIDTH(`SR_DATA_W), .LOG_DEPTH(`RESP_Q_LOG_DEPTH)) u_resp_q (
        .clk      (clk),
        .rst      (rst),
        .push     (q_push),
        .push_data(resp_data),
        .full     (q_full),
        .pop      (q_pop),
        .head     (q_head),
        .empty    (q_empty)
    );

    //////////////////////////////////////////////////
    // R beats, low half then high half
    //////////////////////////////////////////////////

    // no data goes out before its address beat was taken
    assign rvalid = !q_empty && (credit != '0);
    assign rdata  = (r_half == HALF_LO) ? q_head[`AXIL_DATA_W-1:0]
                                        : q_head[`SR_DATA_W-1 -: `AXIL_DATA_W];
    assign rresp  = RESP_OKAY;
    assign r_hs   = rvalid && rready;
    assign q_pop  = r_hs && (r_half == HALF_HI);

    always_ff @(posedge clk) begin
        if (rst) begin
            r_half <= HALF_LO;
            credit <= '0;
        end else begin
            if (r_hs) begin
                r_half <= (r_half == HALF_LO) ? HALF_HI : HALF_LO;
            end
            case ({ar_accept, r_hs})
                2'b10:   credit <= credit + 1'b1;
                2'b01:   credit <= credit - 1'b1;
                default: credit <= credit;
            endcase
        end
    end

endmodule

// ==== hw/axil_sr_bridge.sv ====
`include "axil_sr_cfg.svh"

module axil_sr_bridge import axil_sr_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // write address
    input  logic                    awvalid,
    input  logic [`AXIL_ADDR_W-1:0] awaddr,
    output logic                    awready,
    // write data
    input  logic                    wvalid,
    input  logic [`AXIL_DATA_W-1:0] wdata,
    output logic                    wready,
    // write response
    output logic                    bvalid,
    output axi_resp_t               bresp,
    input  logic                    bready,
    // read address
    input  logic                    arvalid,
    input  logic [`AXIL_ADDR_W-1:0] araddr,
    output logic                    arready,
    // read data
    output logic                    rvalid,
    output logic [`AXIL_DATA_W-1:0] rdata,
    output axi_resp_t               rresp,
    input  logic                    rready,
    // softreg requests
    output logic                    softreg_req_valid,
    output sr_op_t                  softreg_req_op,
    output logic [`AXIL_ADDR_W-1:0] softreg_req_addr,
    output logic [`SR_DATA_W-1:0]   softreg_req_data,
    input  logic                    softreg_req_grant,
    // softreg responses
    input  logic                    softreg_resp_valid,
    input  logic [`SR_DATA_W-1:0]   softreg_resp_data,
    output logic                    softreg_resp_grant
);

    logic ar_accept;

    sr_req_if wr_req ();
    sr_req_if rd_req ();
    sr_req_if sr_out ();

    axil_write_pairer u_wr_pair (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
        .wvalid(wvalid), .wdata(wdata), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .wr_req(wr_req)
    );

    axil_read_pairer u_rd_pair (
        .clk(clk), .rst(rst),
        .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rd_req(rd_req), .ar_accept(ar_accept)
    );

    sr_req_arbiter u_arb (
        .clk(clk), .rst(rst),
        .wr_req(wr_req), .rd_req(rd_req), .sr_out(sr_out)
    );

    sr_read_responder u_rd_resp (
        .clk(clk), .rst(rst),
        .resp_valid(softreg_resp_valid), .resp_data(softreg_resp_data),
        .resp_grant(softreg_resp_grant), .ar_accept(ar_accept),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready)
    );

    // softreg request port
    assign softreg_req_valid = sr_out.valid;
    assign softreg_req_op    = sr_out.op;
    assign softreg_req_addr  = sr_out.addr;
    assign softreg_req_data  = sr_out.data;
    assign sr_out.ready      = softreg_req_grant;

endmodule

// ==== sim/axil_sr_checker.sv ====
module axil_sr_checker import axil_sr_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        awready,
    input logic        wready,
    input logic        arvalid,
    input logic        arready,
    input logic        bvalid,
    input axi_resp_t   bresp,
    input logic        bready,
    input logic        rvalid,
    input logic [31:0] rdata,
    input axi_resp_t   rresp,
    input logic        rready,
    input logic        softreg_req_valid,
    input sr_op_t      softreg_req_op,
    input logic [31:0] softreg_req_addr,
    input logic [63:0] softreg_req_data,
    input logic        softreg_req_grant,
    input logic        softreg_resp_grant
);

    int          errors = 0;
    int          test_errors = 0;
    int          tests = 0;
    int          exp_b = 0;
    int          ar_cnt = 0;
    int          r_cnt = 0;
    logic [96:0] exp_req [$];
    logic [31:0] exp_r [$];
    logic [96:0] exp_head;
    logic [31:0] exp_beat;

    //////////////////////////////////////////////////
    // expectations, filled by the testbench top
    //////////////////////////////////////////////////

    task automatic expect_req(input sr_op_t op, input logic [31:0] a, input logic [63:0] d);
        exp_req.push_back({op, a, d});
    endtask

    task automatic expect_b();
        exp_b = exp_b + 1;
    endtask

    task automatic expect_r(input logic [31:0] d);
        exp_r.push_back(d);
    endtask

    function automatic int pending();
        return exp_req.size() + exp_r.size() + exp_b;
    endfunction

    function automatic void mismatch(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        errors = errors + 1;
        test_errors = test_errors + 1;
    endfunction

    task automatic check_idle();
        if (bvalid || rvalid || softreg_req_valid || softreg_resp_grant) begin
            mismatch("valid or grant output high after reset");
        end
        if (!awready || !wready || !arready) begin
            mismatch("ready output low after reset");
        end
    endtask

    task automatic test_done(input int idx, input string what, input logic [31:0] a);
        $display("test %0d %s at 0x%08h finished with %0d errors", idx, what, a, test_errors);
        test_errors = 0;
        tests = tests + 1;
    endtask

    task automatic summary();
        $display("checks done: %0d tests, %0d errors", tests, errors);
    endtask

    //////////////////////////////////////////////////
    // port monitor
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst) begin
            if (softreg_req_valid && softreg_req_grant) begin
                if (exp_req.size() == 0) begin
                    mismatch("softreg request with none expected");
                end else begin
                    exp_head = exp_req.pop_front();
                    if ({softreg_req_op, softreg_req_addr, softreg_req_data} !== exp_head) begin
                        mismatch($sformatf("softreg request op %0d addr %h data %h, expected %h",
                            softreg_req_op, softreg_req_addr, softreg_req_data, exp_head));
                    end
                end
            end
            if (bvalid && bready) begin
                if (exp_b == 0) begin
                    mismatch("B response with none expected");
                end else begin
                    exp_b = exp_b - 1;
                end
                if (bresp != RESP_OKAY) begin
                    mismatch($sformatf("bresp %0d is not OKAY", bresp));
                end
            end
            // credit check uses AR beats taken before this edge
            if (rvalid && ar_cnt <= r_cnt) begin
                mismatch("rvalid high before its AR beat was accepted");
            end
            if (arvalid && arready) begin
                ar_cnt = ar_cnt + 1;
            end
            if (rvalid && rready) begin
                r_cnt = r_cnt + 1;
                if (exp_r.size() == 0) begin
                    mismatch("R beat with none expected");
                end else begin
                    exp_beat = exp_r.pop_front();
                    if (rdata !== exp_beat) begin
                        mismatch($sformatf("rdata %h, expected %h", rdata, exp_beat));
                    end
                end
                if (rresp != RESP_OKAY) begin
                    mismatch($sformatf("rresp %0d is not OKAY", rresp));
                end
            end
        end
    end

endmodule

// ==== sim/tb_axil_sr.sv ====
module tb_axil_sr import axil_sr_pkg::*; ();

    localparam int          TIMEOUT = 2000;
    localparam int          AR_GAP  = 24;
    localparam logic [31:0] SEED    = 32'h86d170f8;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        awvalid = 1'b0;
    logic [31:0] awaddr = '0;
    logic        awready;
    logic        wvalid = 1'b0;
    logic [31:0] wdata = '0;
    logic        wready;
    logic        bvalid;
    axi_resp_t   bresp;
    logic        bready = 1'b0;
    logic        arvalid = 1'b0;
    logic [31:0] araddr = '0;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    axi_resp_t   rresp;
    logic        rready = 1'b0;
    logic        softreg_req_valid;
    sr_op_t      softreg_req_op;
    logic [31:0] softreg_req_addr;
    logic [63:0] softreg_req_data;
    logic        softreg_req_grant = 1'b0;
    logic        softreg_resp_valid = 1'b0;
    logic [63:0] softreg_resp_data = '0;
    logic        softreg_resp_grant;

    integer      seed = SEED;
    bit          timed_out = 1'b0;
    int          gnt_delay = 0;

    // test table
    sr_op_t      tab_op [$];
    logic [63:0] tab_addr [$];
    logic [63:0] tab_data [$];

    // expected contents, from the table alone
    logic [63:0] exp_mem [logic [31:0]];

    // softreg target state
    logic [63:0] sr_mem [logic [31:0]];
    logic [63:0] resp_q [$];

    always #4 clk = ~clk;

    axil_sr_bridge DUT (.*);

    axil_sr_checker chk (.*);

    //////////////////////////////////////////////////
    // softreg target model and random stalls
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            softreg_req_grant  <= 1'b0;
            softreg_resp_valid <= 1'b0;
            bready             <= 1'b0;
            rready             <= 1'b0;
        end else begin
            bready            <= (($random(seed) & 3) != 0);
            rready            <= (($random(seed) & 3) != 0);
            softreg_req_grant <= 1'b0;
            if (softreg_resp_valid && softreg_resp_grant) begin
                void'(resp_q.pop_front());
            end
            if (softreg_req_valid && !softreg_req_grant) begin
                if (gnt_delay == 0) begin
                    softreg_req_grant <= 1'b1;
                    gnt_delay = $random(seed) & 7;
                    if (softreg_req_op == SR_WRITE) begin
                        sr_mem[softreg_req_addr] = softreg_req_data;
                    end else if (sr_mem.exists(softreg_req_addr)) begin
                        resp_q.push_back(sr_mem[softreg_req_addr]);
                    end else begin
                        resp_q.push_back({~softreg_req_addr, softreg_req_addr});
                    end
                end else begin
                    gnt_delay = gnt_delay - 1;
                end
            end
            softreg_resp_valid <= (resp_q.size() != 0);
            softreg_resp_data  <= (resp_q.size() != 0) ? resp_q[0] : '0;
        end
    end

    //////////////////////////////////////////////////
    // AXI master driver
    //////////////////////////////////////////////////

    task automatic add_entry(input sr_op_t op, input logic [63:0] a, input logic [63:0] d);
        tab_op.push_back(op);
        tab_addr.push_back(a);
        tab_data.push_back(d);
    endtask

    task automatic note_timeout(input string what);
        $display("timeout while waiting for %s", what);
        timed_out = 1'b1;
    endtask

    task automatic send_aw(input logic [31:0] a);
        int n;
        n = 0;
        awvalid <= 1'b1;
        awaddr  <= a;
        @(posedge clk);
        while (!awready && !timed_out) begin
            n = n + 1;
            if (n > TIMEOUT) note_timeout("awready");
            @(posedge clk);
        end
        awvalid <= 1'b0;
    endtask

    task automatic send_w(input logic [31:0] d);
        int n;
        n = 0;
        wvalid <= 1'b1;
        wdata  <= d;
        @(posedge clk);
        while (!wready && !timed_out) begin
            n = n + 1;
            if (n > TIMEOUT) note_timeout("wready");
            @(posedge clk);
        end
        wvalid <= 1'b0;
    endtask

    task automatic send_ar(input logic [31:0] a);
        int n;
        n = 0;
        arvalid <= 1'b1;
        araddr  <= a;
        @(posedge clk);
        while (!arready && !timed_out) begin
            n = n + 1;
            if (n > TIMEOUT) note_timeout("arready");
            @(posedge clk);
        end
        arvalid <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (chk.pending() != 0 && !timed_out) begin
            n = n + 1;
            if (n > TIMEOUT) note_timeout("the expected responses to finish");
            @(posedge clk);
        end
    endtask

    task automatic run_entry(input int i);
        logic [31:0] a;
        logic [63:0] d;
        logic [63:0] v;
        a = tab_addr[i][31:0];
        d = tab_data[i];
        if (tab_op[i] == SR_WRITE) begin
            exp_mem[a] = d;
            chk.expect_req(SR_WRITE, a, d);
            chk.expect_b();
            chk.expect_b();
            send_aw(a);
            send_aw(a + 32'd4);
            send_w(d[31:0]);
            send_w(d[63:32]);
        end else begin
            v = exp_mem.exists(a) ? exp_mem[a] : {~a, a};
            chk.expect_req(SR_READ, a, 64'h0);
            chk.expect_r(v[31:0]);
            chk.expect_r(v[63:32]);
            send_ar(a);
            // second beat held back so the response waits on a single credit
            repeat (AR_GAP) @(posedge clk);
            send_ar(a + 32'd4);
        end
        wait_drain();
        chk.test_done(i, (tab_op[i] == SR_WRITE) ? "write" : "read", a);
    endtask

    initial begin
        add_entry(SR_WRITE, 64'h100, 64'h1122334455667788);
        add_entry(SR_READ,  64'h100, 64'h0);
        add_entry(SR_READ,  64'h200, 64'h0);
        add_entry(SR_WRITE, 64'h208, 64'hdeadbeef0badf00d);
        add_entry(SR_WRITE, 64'h300, 64'h0123456789abcdef);
        add_entry(SR_READ,  64'h208, 64'h0);
        add_entry(SR_READ,  64'h300, 64'h0);
        add_entry(SR_WRITE, 64'h100, 64'hcafef00d12345678);
        add_entry(SR_READ,  64'h100, 64'h0);
        add_entry(SR_READ,  64'h4f8, 64'h0);
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        chk.check_idle();
        for (int i = 0; i < tab_op.size(); i++) begin
            if (!timed_out) run_entry(i);
        end
        chk.summary();
        if (timed_out || chk.errors != 0) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/axil_sr_pkg.sv
hw/sr_req_if.sv
hw/sr_fifo.sv
hw/axil_write_pairer.sv
hw/axil_read_pairer.sv
hw/sr_req_arbiter.sv
hw/sr_read_responder.sv
hw/axil_sr_bridge.sv
sim/axil_sr_checker.sv
sim/tb_axil_sr.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_axil_sr -f filelist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" sim.log; then
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "simulation log has no pass line"
    exit 1
fi
exit 0
